/* design/corePkg.sv */
package corePkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int regAddrWidth = 4;
    localparam int regCount     = 16;
    localparam int instrWidth   = 16;
    localparam int wbDataWidth  = 16;  // matches the default dataWidth

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        opAdd  = 2'd0,
        opSub  = 2'd1,
        opXor  = 2'd2,
        opLoad = 2'd3
    } opCode;

    typedef struct packed {
        opCode                                  op;
        logic [regAddrWidth-1:0]                dst;
        logic [regAddrWidth-1:0]                srcA;
        logic [regAddrWidth-1:0]                srcB;
        logic [instrWidth-3*regAddrWidth-3:0]   spare;
    } aluForm;

    typedef struct packed {
        opCode                                  op;
        logic [regAddrWidth-1:0]                dst;
        logic [regAddrWidth-1:0]                base;
        logic [instrWidth-2*regAddrWidth-3:0]   offset;  // unsigned
    } loadForm;

    // op lines up in both forms
    typedef union packed {
        aluForm  alu;
        loadForm load;
    } instrWord;

    // one register write
    typedef struct packed {
        logic                    valid;
        logic [regAddrWidth-1:0] addr;
        logic [wbDataWidth-1:0]  data;
    } wbPacket;

endpackage

/* design/regCell.sv */
module regCell #(
    parameter int dataWidth = 16
)(
    input  logic                 clk,
    input  logic                 clkEn,
    input  logic                 rstN,
    input  logic                 writeEn,
    input  logic [dataWidth-1:0] dataIn,
    input  logic                 memWriteEn,
    input  logic [dataWidth-1:0] memDataIn,
    input  logic                 dirtySet,
    output logic [dataWidth-1:0] dataOut,
    output logic                 dirtyOut
);

    // any write retires the pending tag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dirtyOut <= 1'b0;
        end else if (clkEn) begin
            if (writeEn || memWriteEn) dirtyOut <= 1'b0;
            else if (dirtySet)         dirtyOut <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (memWriteEn)   dataOut <= memDataIn;  // memory port wins
            else if (writeEn) dataOut <= dataIn;
        end
    end

endmodule

/* design/registerFile.sv */
module registerFile import corePkg::*; #(
    parameter int dataWidth = 16
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] readAAddr,
    input  logic                    readAEn,
    output logic [dataWidth-1:0]    readAData,
    input  logic [regAddrWidth-1:0] readBAddr,
    input  logic                    readBEn,
    output logic [dataWidth-1:0]    readBData,
    input  logic                    tagEn,
    input  logic [regAddrWidth-1:0] tagAddr,
    input  wbPacket                 aluWb,
    input  wbPacket                 memWb,
    output logic                    readStall,
    output logic                    regSync
);

    logic [regCount-1:0]  aluDecode;
    logic [regCount-1:0]  memDecode;
    logic [regCount-1:0]  tagDecode;
    logic [dataWidth-1:0] cellData [regCount];
    logic [regCount-1:0]  cellDirty;
    logic                 stallA;
    logic                 stallB;
    logic                 stallTag;

    //////////////////////////////////////////////////
    // one-hot strobes
    //////////////////////////////////////////////////

    always_comb begin
        aluDecode = '0;
        aluDecode[aluWb.addr] = aluWb.valid;
    end

    always_comb begin
        memDecode = '0;
        memDecode[memWb.addr] = memWb.valid;
    end

    // tag only lands when the issue goes through
    always_comb begin
        tagDecode = '0;
        tagDecode[tagAddr] = tagEn && !readStall;
    end

    //////////////////////////////////////////////////
    // cells, r0 hardwired
    //////////////////////////////////////////////////

    assign cellData[0]  = '0;
    assign cellDirty[0] = 1'b0;

    for (genvar i = 1; i < regCount; i++) begin : genCell
        regCell #(.dataWidth(dataWidth)) cell_i (
            .clk        (clk),
            .clkEn      (clkEn),
            .rstN       (rstN),
            .writeEn    (aluDecode[i]),
            .dataIn     (aluWb.data),
            .memWriteEn (memDecode[i]),
            .memDataIn  (memWb.data),
            .dirtySet   (tagDecode[i]),
            .dataOut    (cellData[i]),
            .dirtyOut   (cellDirty[i])
        );
    end

    assign readAData = readAEn ? cellData[readAAddr] : '0;
    assign readBData = readBEn ? cellData[readBAddr] : '0;

    // source hazards plus write-after-write on the destination
    assign stallA    = readAEn && cellDirty[readAAddr];
    assign stallB    = readBEn && cellDirty[readBAddr];
    assign stallTag  = tagEn && cellDirty[tagAddr];
    assign readStall = stallA || stallB || stallTag;
    assign regSync   = ~|cellDirty;

endmodule

/* design/issueStage.sv */
module issueStage import corePkg::*; #(
    parameter int dataWidth    = 16,
    parameter int memAddrWidth = 6
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rstN,
    input  instrWord                instr,
    input  logic                    instrValid,
    output logic                    stall,
    output logic [regAddrWidth-1:0] readAAddr,
    output logic                    readAEn,
    output logic [regAddrWidth-1:0] readBAddr,
    output logic                    readBEn,
    output logic                    tagEn,
    output logic [regAddrWidth-1:0] tagAddr,
    input  logic [dataWidth-1:0]    readAData,
    input  logic [dataWidth-1:0]    readBData,
    input  logic                    readStall,
    output wbPacket                 aluWb,
    output wbPacket                 loadReq
);

    opCode                   op;
    logic                    isLoad;
    logic                    accept;
    logic [dataWidth-1:0]    aluResult;
    logic [memAddrWidth-1:0] loadAddr;
    logic                    aluValid;
    logic                    loadValid;
    logic [regAddrWidth-1:0] aluDst;
    logic [regAddrWidth-1:0] loadDst;
    logic [dataWidth-1:0]    aluData;
    logic [memAddrWidth-1:0] loadAddrQ;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign op     = instr.alu.op;
    assign isLoad = (op == opLoad);

    assign readAAddr = instr.load.base;  // srcA shares these bits
    assign readAEn   = instrValid;
    assign readBAddr = instr.alu.srcB;
    assign readBEn   = instrValid && !isLoad;  // loads use base only
    assign tagAddr   = instr.alu.dst;
    assign tagEn     = instrValid;

    assign stall  = readStall;
    assign accept = instrValid && !readStall;

    always_comb begin
        case (op)
            opAdd:   aluResult = readAData + readBData;
            opSub:   aluResult = readAData - readBData;
            opXor:   aluResult = readAData ^ readBData;
            default: aluResult = '0;
        endcase
    end

    // base plus offset, wraps in the memory
    assign loadAddr = memAddrWidth'(readAData + dataWidth'(instr.load.offset));

    //////////////////////////////////////////////////
    // issue registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluValid  <= 1'b0;
            loadValid <= 1'b0;
        end else if (clkEn) begin
            aluValid  <= accept && !isLoad;
            loadValid <= accept && isLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            aluDst    <= instr.alu.dst;
            aluData   <= aluResult;
            loadDst   <= instr.load.dst;
            loadAddrQ <= loadAddr;
        end
    end

    assign aluWb   = '{valid: aluValid, addr: aluDst, data: aluData};
    assign loadReq = '{valid: loadValid, addr: loadDst, data: wbDataWidth'(loadAddrQ)};

endmodule

/* design/loadUnit.sv */
module loadUnit import corePkg::*; #(
    parameter int dataWidth    = 16,
    parameter int memAddrWidth = 6,
    parameter int loadLatency  = 3
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rstN,
    input  wbPacket                 loadReq,
    input  logic                    preloadEn,
    input  logic [memAddrWidth-1:0] preloadAddr,
    input  logic [dataWidth-1:0]    preloadData,
    output wbPacket                 loadWb
);

    // request arrives one cycle after issue, output register is the last stage
    localparam int pipeDepth = loadLatency - 1;
    localparam int memWords  = 2 ** memAddrWidth;

    logic [dataWidth-1:0]    mem [memWords];
    logic [memAddrWidth-1:0] reqAddr;
    logic [pipeDepth-1:0]    pipeValid;
    logic [regAddrWidth-1:0] pipeDst  [pipeDepth];
    logic [dataWidth-1:0]    pipeData [pipeDepth];

    //////////////////////////////////////////////////
    // data memory
    //////////////////////////////////////////////////

    assign reqAddr = loadReq.data[memAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (clkEn && preloadEn) begin
            mem[preloadAddr] <= preloadData;
        end
    end

    //////////////////////////////////////////////////
    // latency pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pipeValid <= '0;
        end else if (clkEn) begin
            pipeValid[0] <= loadReq.valid;
            for (int i = 1; i < pipeDepth; i++) begin
                pipeValid[i] <= pipeValid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            pipeDst[0]  <= loadReq.addr;
            pipeData[0] <= mem[reqAddr];  // read on arrival
            for (int i = 1; i < pipeDepth; i++) begin
                pipeDst[i]  <= pipeDst[i-1];
                pipeData[i] <= pipeData[i-1];
            end
        end
    end

    assign loadWb = '{
        valid: pipeValid[pipeDepth-1],
        addr:  pipeDst[pipeDepth-1],
        data:  pipeData[pipeDepth-1]
    };

endmodule

/* design/coreTop.sv */
module coreTop import corePkg::*; #(
    parameter int dataWidth    = 16,
    parameter int loadLatency  = 3,
    parameter int memAddrWidth = 6
)(
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rstN,
    input  instrWord                instr,
    input  logic                    instrValid,
    output logic                    stall,
    input  logic                    preloadEn,
    input  logic [memAddrWidth-1:0] preloadAddr,
    input  logic [dataWidth-1:0]    preloadData,
    output wbPacket                 aluWb,
    output wbPacket                 loadWb,
    output logic                    regSync
);

    logic [regAddrWidth-1:0] readAAddr;
    logic                    readAEn;
    logic [regAddrWidth-1:0] readBAddr;
    logic                    readBEn;
    logic [dataWidth-1:0]    readAData;
    logic [dataWidth-1:0]    readBData;
    logic                    tagEn;
    logic [regAddrWidth-1:0] tagAddr;
    logic                    readStall;
    wbPacket                 loadReq;

    issueStage #(.dataWidth(dataWidth), .memAddrWidth(memAddrWidth)) issue_i (
        .clk(clk), .clkEn(clkEn), .rstN(rstN),
        .instr(instr), .instrValid(instrValid), .stall(stall),
        .readAAddr(readAAddr), .readAEn(readAEn),
        .readBAddr(readBAddr), .readBEn(readBEn),
        .tagEn(tagEn), .tagAddr(tagAddr),
        .readAData(readAData), .readBData(readBData), .readStall(readStall),
        .aluWb(aluWb), .loadReq(loadReq)
    );

    // both writebacks also leave the slice
    registerFile #(.dataWidth(dataWidth)) regs_i (
        .clk(clk), .clkEn(clkEn), .rstN(rstN),
        .readAAddr(readAAddr), .readAEn(readAEn), .readAData(readAData),
        .readBAddr(readBAddr), .readBEn(readBEn), .readBData(readBData),
        .tagEn(tagEn), .tagAddr(tagAddr),
        .aluWb(aluWb), .memWb(loadWb),
        .readStall(readStall), .regSync(regSync)
    );

    loadUnit #(
        .dataWidth(dataWidth), .memAddrWidth(memAddrWidth), .loadLatency(loadLatency)
    ) load_i (
        .clk(clk), .clkEn(clkEn), .rstN(rstN),
        .loadReq(loadReq),
        .preloadEn(preloadEn), .preloadAddr(preloadAddr), .preloadData(preloadData),
        .loadWb(loadWb)
    );

endmodule

/* tb/coreTb.sv */
module coreTb import corePkg::*; ();

    localparam int dataWidth    = 16;
    localparam int loadLatency  = 3;
    localparam int memAddrWidth = 6;
    localparam int memWords     = 2 ** memAddrWidth;
    localparam int clkPeriod    = 40;
    localparam int randomCount  = 200;
    localparam int fixedInstr   = 38;
    localparam int totalInstr   = fixedInstr + randomCount;
    // reset, preload and drains fit in the margin
    localparam int watchdogTime =
        totalInstr * (loadLatency + 2) * clkPeriod + 200 * clkPeriod;

    logic                    clk;
    logic                    clkEn;
    logic                    rstN;
    instrWord                instr;
    logic                    instrValid;
    logic                    stall;
    logic                    preloadEn;
    logic [memAddrWidth-1:0] preloadAddr;
    logic [dataWidth-1:0]    preloadData;
    wbPacket                 aluWb;
    wbPacket                 loadWb;
    logic                    regSync;

    logic [dataWidth-1:0] modelReg [regCount];
    logic [dataWidth-1:0] modelMem [memWords];
    logic [dataWidth-1:0] expQ [regCount][$];
    int                   dueQ [regCount][$];  // 2 * due edge + port
    int                   edgeCount = 0;
    int                   checkCount;
    int                   errorCount;
    int                   testErrors;
    int                   stallCycles;

    coreTop #(
        .dataWidth(dataWidth), .loadLatency(loadLatency), .memAddrWidth(memAddrWidth)
    ) dut_i (
        .clk(clk), .clkEn(clkEn), .rstN(rstN),
        .instr(instr), .instrValid(instrValid), .stall(stall),
        .preloadEn(preloadEn), .preloadAddr(preloadAddr), .preloadData(preloadData),
        .aluWb(aluWb), .loadWb(loadWb), .regSync(regSync)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) edgeCount <= edgeCount + 1;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic instrWord aluInstr(input opCode op, input int dst,
                                          input int srcA, input int srcB);
        instrWord w;
        w = '0;
        w.alu.op   = op;
        w.alu.dst  = regAddrWidth'(dst);
        w.alu.srcA = regAddrWidth'(srcA);
        w.alu.srcB = regAddrWidth'(srcB);
        return w;
    endfunction

    function automatic instrWord loadInstr(input int dst, input int base, input int offset);
        instrWord w;
        w = '0;
        w.load.op     = opLoad;
        w.load.dst    = regAddrWidth'(dst);
        w.load.base   = regAddrWidth'(base);
        w.load.offset = 6'(offset);
        return w;
    endfunction

    // program order, r0 keeps reading zero
    function automatic void modelExecute(input instrWord w);
        logic [dataWidth-1:0]    value;
        logic [memAddrWidth-1:0] addr;
        case (w.alu.op)
            opAdd: value = modelReg[w.alu.srcA] + modelReg[w.alu.srcB];
            opSub: value = modelReg[w.alu.srcA] - modelReg[w.alu.srcB];
            opXor: value = modelReg[w.alu.srcA] ^ modelReg[w.alu.srcB];
            default: begin
                addr  = memAddrWidth'(modelReg[w.load.base] + dataWidth'(w.load.offset));
                value = modelMem[addr];
            end
        endcase
        expQ[w.alu.dst].push_back(value);
        if (w.alu.dst != 0) modelReg[w.alu.dst] = value;
    endfunction

    function automatic logic queuesEmpty();
        logic empty;
        int   r;
        empty = 1'b1;
        for (r = 0; r < regCount; r++) begin
            if (expQ[r].size() != 0) empty = 1'b0;
        end
        return empty;
    endfunction

    //////////////////////////////////////////////////
    // compare
    //////////////////////////////////////////////////

    task automatic checkWriteback(input string name, input wbPacket wb, input logic fromLoad);
        int                   key;
        int                   idx;
        int                   i;
        logic [dataWidth-1:0] expData;
        key = 2 * edgeCount + int'(fromLoad);
        idx = -1;
        checkCount++;
        for (i = 0; i < dueQ[wb.addr].size(); i++) begin
            if (idx < 0 && dueQ[wb.addr][i] == key) idx = i;
        end
        assert (expQ[wb.addr].size() != 0) else begin
            $display("%0t: unexpected writeback on %s to register %0d", $time, name, wb.addr);
            errorCount++;
        end
        if (expQ[wb.addr].size() != 0) begin
            assert (idx >= 0) else begin
                $display("Fail %0t %s.valid r%0d expected cycle %0d got %0d", $time, name,
                         wb.addr, dueQ[wb.addr][0] / 2, edgeCount);
                errorCount++;
                idx = 0;
            end
            expData = expQ[wb.addr][idx];
            expQ[wb.addr].delete(idx);
            dueQ[wb.addr].delete(idx);
            assert (wb.data == expData) else begin
                $display("Fail %0t %s.data r%0d expected %h got %h", $time, name,
                         wb.addr, expData, wb.data);
                errorCount++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            if (aluWb.valid) checkWriteback("aluWb", aluWb, 1'b0);
            if (loadWb.valid) checkWriteback("loadWb", loadWb, 1'b1);
        end
    end

    task automatic checkLevel(input string name, input logic got, input logic exp);
        checkCount++;
        assert (got == exp) else begin
            $display("Fail %0t %s expected %b got %b", $time, name, exp, got);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic issue(input instrWord w);
        logic accepted;
        int   lat;
        accepted = 1'b0;
        lat = (w.alu.op == opLoad) ? loadLatency : 1;
        instr = w;
        instrValid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            if (accepted) begin
                dueQ[w.alu.dst].push_back(2 * (edgeCount + lat) + int'(w.alu.op == opLoad));
            end else begin
                stallCycles++;
            end
            @(posedge clk);
            #5;
        end
        instrValid = 1'b0;
    endtask

    task automatic run(input instrWord w);
        modelExecute(w);
        issue(w);
    endtask

    // the last writeback lands within loadLatency edges of the last issue
    task automatic drain();
        int waited;
        waited = 0;
        while (!queuesEmpty() && waited < loadLatency + 2) begin
            @(posedge clk);
            #5;
            waited++;
        end
        checkLevel("queues empty", queuesEmpty(), 1'b1);
    endtask

    task automatic preloadMemory();
        logic [dataWidth-1:0] value;
        int                   a;
        for (a = 0; a < memWords; a++) begin
            value = dataWidth'($urandom);
            modelMem[a] = value;
            preloadEn   = 1'b1;
            preloadAddr = memAddrWidth'(a);
            preloadData = value;
            @(posedge clk);
            #5;
        end
        preloadEn = 1'b0;
    endtask

    task automatic reportTest(input string name);
        if (errorCount == testErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    initial begin
        int       r;
        int       n;
        int       stallBefore;
        instrWord w;
        void'($urandom(32'hef05));
        clkEn       = 1'b1;
        rstN        = 1'b0;
        instr       = '0;
        instrValid  = 1'b0;
        preloadEn   = 1'b0;
        preloadAddr = '0;
        preloadData = '0;
        checkCount  = 0;
        errorCount  = 0;
        testErrors  = 0;
        stallCycles = 0;
        for (r = 0; r < regCount; r++) modelReg[r] = '0;
        repeat (5) @(posedge clk);
        #5;
        rstN = 1'b1;

        @(negedge clk);
        checkLevel("stall", stall, 1'b0);
        checkLevel("regSync", regSync, 1'b1);
        checkLevel("aluWb.valid", aluWb.valid, 1'b0);
        checkLevel("loadWb.valid", loadWb.valid, 1'b0);
        reportTest("reset and idle");
        @(posedge clk);
        #5;

        // every register gets a known value first
        preloadMemory();
        for (r = 1; r < regCount; r++) run(loadInstr(r, 0, r));
        drain();
        stallBefore = stallCycles;
        run(aluInstr(opAdd, 10, 1, 2));
        run(aluInstr(opSub, 11, 3, 4));
        run(aluInstr(opXor, 12, 5, 6));
        drain();
        checkLevel("stall", stallCycles != stallBefore, 1'b0);
        reportTest("independent alu ops");

        stallBefore = stallCycles;
        for (r = 8; r < regCount; r++) run(loadInstr(r, 1 + (r % 4), $urandom % 64));
        drain();
        checkLevel("stall", stallCycles != stallBefore, 1'b0);  // all in flight together
        reportTest("loads");

        stallBefore = stallCycles;
        run(loadInstr(5, 1, 3));
        run(aluInstr(opAdd, 6, 5, 2));
        checkLevel("stall", stallCycles != stallBefore, 1'b1);
        run(aluInstr(opAdd, 7, 1, 2));
        run(loadInstr(7, 3, 9));
        run(aluInstr(opXor, 7, 7, 4));
        run(loadInstr(7, 7, 0));
        run(aluInstr(opSub, 8, 7, 6));
        drain();
        reportTest("hazards");

        run(aluInstr(opAdd, 0, 1, 2));
        run(loadInstr(0, 0, 7));
        run(aluInstr(opXor, 0, 3, 4));  // overtakes the load to r0
        drain();
        run(aluInstr(opAdd, 9, 0, 0));
        run(aluInstr(opSub, 10, 5, 0));
        drain();
        reportTest("register zero");

        for (n = 0; n < randomCount; n++) begin
            w = instrWidth'($urandom);
            run(w);
        end
        drain();
        checkLevel("regSync", regSync, 1'b1);
        reportTest("random mix");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("timeout at %0t, the DUT stopped making progress", $time);
        $display("tests failed");
        $finish;
    end

endmodule

/* sources.f */
design/corePkg.sv
design/regCell.sv
design/registerFile.sv
design/issueStage.sv
design/loadUnit.sv
design/coreTop.sv
tb/coreTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = coreTb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
